//--- Makefile
TOP := tb_mc_bridge

.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/mc_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module mc_bridge
  import mc_bridge_pkg::*;
  (input  logic             clk_i
   , input  logic           rst_n_i

   // processor command port
   , input  logic           cmd_v_i
   , input  mc_cmd_s        cmd_i
   , output logic           cmd_ready_o

   , input  logic [X_W-1:0] my_x_i
   , input  logic [Y_W-1:0] my_y_i

   // network request
   , output logic           pkt_v_o
   , output mc_packet_s     pkt_o

   // network return
   , input  logic           ret_v_i
   , input  mc_ret_s        ret_i

   // processor response
   , output logic           resp_v_o
   , output mc_resp_s       resp_o
   );

  mc_dest_s          dest;
  mc_op_s            op;
  logic              alloc_v;
  logic [TID_W-1:0]  alloc_id;
  mc_hdr_s           alloc_hdr;
  logic              rel_v;

  // routing and op encoding run side by side on the raw command
  mc_dest_map u_dest_map
    (.cmd_addr_i (cmd_i.hdr.addr)
     ,.my_x_i    (my_x_i)
     ,.my_y_i    (my_y_i)
     ,.dest_o    (dest)
     );

  mc_op_encode u_op_encode
    (.cmd_i (cmd_i)
     ,.op_o (op)
     );

  mc_req_issue u_req_issue
    (.clk_i        (clk_i)
     ,.rst_n_i     (rst_n_i)
     ,.cmd_v_i     (cmd_v_i)
     ,.cmd_i       (cmd_i)
     ,.dest_i      (dest)
     ,.op_i        (op)
     ,.my_x_i      (my_x_i)
     ,.my_y_i      (my_y_i)
     ,.rel_v_i     (rel_v)
     ,.cmd_ready_o (cmd_ready_o)
     ,.pkt_v_o     (pkt_v_o)
     ,.pkt_o       (pkt_o)
     ,.alloc_v_o   (alloc_v)
     ,.alloc_id_o  (alloc_id)
     ,.alloc_hdr_o (alloc_hdr)
     );

  mc_return_reorder u_return_reorder
    (.clk_i        (clk_i)
     ,.rst_n_i     (rst_n_i)
     ,.alloc_v_i   (alloc_v)
     ,.alloc_id_i  (alloc_id)
     ,.alloc_hdr_i (alloc_hdr)
     ,.ret_v_i     (ret_v_i)
     ,.ret_i       (ret_i)
     ,.resp_v_o    (resp_v_o)
     ,.resp_o      (resp_o)
     ,.rel_v_o     (rel_v)
     );

endmodule

`default_nettype wire

//--- hdl/mc_bridge_pkg.sv
`default_nettype none

package mc_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int PADDR_W     = 40;
  localparam int MC_DATA_W   = 32;
  localparam int MC_MASK_W   = MC_DATA_W / 8;
  localparam int MC_ADDR_W   = 28;
  localparam int X_W         = 6;
  localparam int Y_W         = 6;
  localparam int TILE_ADDR_W = 18;

  // outstanding transactions
  localparam int MAX_OUT   = 4;
  localparam int TID_W     = 2;
  localparam int OUT_CNT_W = TID_W + 1;
  // reg id is the store mask stacked on the transaction id
  localparam int REG_ID_W  = MC_MASK_W + TID_W;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////
  localparam logic [PADDR_W-1:0] DRAM_BASE  = 40'h00_8000_0000;
  // dram sits on the last network row
  localparam logic [Y_W-1:0]     DRAM_ROW_Y = {Y_W{1'b1}};

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////
  typedef enum logic
  {
    e_msg_rd = 1'b0,
    e_msg_wr = 1'b1
  } msg_type_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } msg_size_e;

  typedef enum logic [1:0]
  {
    e_remote_load  = 2'd0,
    e_remote_store = 2'd1,
    e_remote_sw    = 2'd2
  } mc_op_e;

  // kept per transaction until its response goes out
  typedef struct packed
  {
    msg_type_e           msg_type;
    msg_size_e           size;
    logic [PADDR_W-1:0]  addr;
  } mc_hdr_s;

  typedef struct packed
  {
    mc_hdr_s               hdr;
    logic [MC_DATA_W-1:0]  data;
  } mc_cmd_s;

  typedef struct packed
  {
    logic [X_W-1:0]        x_cord;
    logic [Y_W-1:0]        y_cord;
    logic [MC_ADDR_W-1:0]  addr;
  } mc_dest_s;

  typedef struct packed
  {
    mc_op_e                op;
    logic [MC_DATA_W-1:0]  payload;
    logic [MC_MASK_W-1:0]  mask;
  } mc_op_s;

  // load payload, the remote side uses it to extract a subword
  typedef struct packed
  {
    logic [MC_DATA_W-5:0]  reserved;
    logic                  is_byte_op;
    logic                  is_hex_op;
    logic [1:0]            part_sel;
  } mc_load_info_s;

  typedef struct packed
  {
    logic [MC_ADDR_W-1:0]  addr;
    mc_op_e                op;
    logic [REG_ID_W-1:0]   reg_id;
    logic [MC_DATA_W-1:0]  payload;
    logic [Y_W-1:0]        src_y_cord;
    logic [X_W-1:0]        src_x_cord;
    logic [Y_W-1:0]        y_cord;
    logic [X_W-1:0]        x_cord;
  } mc_packet_s;

  typedef struct packed
  {
    logic [REG_ID_W-1:0]   reg_id;
    logic [MC_DATA_W-1:0]  data;
  } mc_ret_s;

  typedef struct packed
  {
    mc_hdr_s               hdr;
    logic [MC_DATA_W-1:0]  data;
  } mc_resp_s;

endpackage

`default_nettype wire

//--- hdl/mc_dest_map.sv
`timescale 1ns/1ns
`default_nettype none

module mc_dest_map
  import mc_bridge_pkg::*;
  (input  logic [PADDR_W-1:0] cmd_addr_i
   , input  logic [X_W-1:0]   my_x_i
   , input  logic [Y_W-1:0]   my_y_i
   , output mc_dest_s         dest_o
   );

  logic                 is_tile;
  logic                 is_dram;
  logic [PADDR_W-3:0]   word_idx;

  // byte address to 32-bit word index
  assign word_idx = cmd_addr_i[PADDR_W-1:2];

  ////////////////////////////////////////////////////////////
  // address class
  ////////////////////////////////////////////////////////////
  assign is_tile = (cmd_addr_i[PADDR_W-1 -: 2] == 2'b11);
  assign is_dram = ~cmd_addr_i[PADDR_W-1] & (cmd_addr_i >= DRAM_BASE);

  ////////////////////////////////////////////////////////////
  // coordinates and network word address
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (is_tile)
    begin
      // tile local word address, then x, then y above it
      dest_o.addr   = MC_ADDR_W'(cmd_addr_i[2 +: TILE_ADDR_W]);
      dest_o.x_cord = cmd_addr_i[2+TILE_ADDR_W +: X_W];
      dest_o.y_cord = cmd_addr_i[2+TILE_ADDR_W+X_W +: Y_W];
    end
    else if (is_dram)
    begin
      // stripe consecutive words across the dram columns
      dest_o.addr   = word_idx[X_W +: MC_ADDR_W];
      dest_o.x_cord = word_idx[X_W-1:0];
      dest_o.y_cord = DRAM_ROW_Y;
    end
    else
    begin
      // host hangs off the row just above this link
      dest_o.addr   = word_idx[MC_ADDR_W-1:0];
      dest_o.x_cord = '0;
      dest_o.y_cord = my_y_i - Y_W'(1);
    end
  end

endmodule

`default_nettype wire

//--- hdl/mc_op_encode.sv
`timescale 1ns/1ns
`default_nettype none

module mc_op_encode
  import mc_bridge_pkg::*;
  (input  mc_cmd_s  cmd_i
   , output mc_op_s op_o
   );

  logic [1:0]            low_bits;
  logic [MC_MASK_W-1:0]  size_mask;
  logic [MC_MASK_W-1:0]  store_mask;
  mc_load_info_s         load_info;

  assign low_bits = cmd_i.hdr.addr[1:0];

  ////////////////////////////////////////////////////////////
  // store byte mask
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (cmd_i.hdr.size)
      e_size_1:
        size_mask = 4'h1;
      e_size_2:
        size_mask = 4'h3;
      default:
        size_mask = 4'hf;
    endcase
  end

  // aligned accesses only, so the shift never spills
  assign store_mask = size_mask << low_bits;

  ////////////////////////////////////////////////////////////
  // load info
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    load_info            = '0;
    load_info.is_byte_op = (cmd_i.hdr.size == e_size_1);
    load_info.is_hex_op  = (cmd_i.hdr.size == e_size_2);
    load_info.part_sel   = low_bits;
  end

  ////////////////////////////////////////////////////////////
  // op select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (cmd_i.hdr.msg_type == e_msg_rd)
    begin
      op_o.op      = e_remote_load;
      op_o.payload = load_info;
      op_o.mask    = '0;
    end
    else
    begin
      op_o.payload = cmd_i.data;
      op_o.mask    = store_mask;
      // full word stores skip the mask on the remote side
      if (store_mask == {MC_MASK_W{1'b1}})
        op_o.op = e_remote_sw;
      else
        op_o.op = e_remote_store;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mc_req_issue.sv
`timescale 1ns/1ns
`default_nettype none

module mc_req_issue
  import mc_bridge_pkg::*;
  (input  logic               clk_i
   , input  logic             rst_n_i

   , input  logic             cmd_v_i
   , input  mc_cmd_s          cmd_i
   , input  mc_dest_s         dest_i
   , input  mc_op_s           op_i
   , input  logic [X_W-1:0]   my_x_i
   , input  logic [Y_W-1:0]   my_y_i
   , input  logic             rel_v_i

   , output logic             cmd_ready_o
   , output logic             pkt_v_o
   , output mc_packet_s       pkt_o

   , output logic             alloc_v_o
   , output logic [TID_W-1:0] alloc_id_o
   , output mc_hdr_s          alloc_hdr_o
   );

  logic [TID_W-1:0]      tid_r;
  logic [OUT_CNT_W-1:0]  out_cnt_r;
  logic                  accept;
  logic                  pkt_v_r;
  mc_packet_s            pkt_r;

  // room for another transaction
  assign cmd_ready_o = (out_cnt_r < OUT_CNT_W'(MAX_OUT));
  assign accept      = cmd_v_i & cmd_ready_o;

  ////////////////////////////////////////////////////////////
  // id rotation and outstanding count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      tid_r     <= '0;
      out_cnt_r <= '0;
    end
    else
    begin
      if (accept)
        tid_r <= tid_r + 1'b1;

      // accept and release in one cycle cancel out
      if (accept & ~rel_v_i)
        out_cnt_r <= out_cnt_r + 1'b1;
      else if (~accept & rel_v_i)
        out_cnt_r <= out_cnt_r - 1'b1;
    end
  end

  // header and id go to the reorder buffer in the accept cycle
  assign alloc_v_o   = accept;
  assign alloc_id_o  = tid_r;
  assign alloc_hdr_o = cmd_i.hdr;

  ////////////////////////////////////////////////////////////
  // packet register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      pkt_v_r <= 1'b0;
    else
      pkt_v_r <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      pkt_r.addr       <= dest_i.addr;
      pkt_r.op         <= op_i.op;
      pkt_r.reg_id     <= {op_i.mask, tid_r};
      pkt_r.payload    <= op_i.payload;
      pkt_r.src_y_cord <= my_y_i;
      pkt_r.src_x_cord <= my_x_i;
      pkt_r.y_cord     <= dest_i.y_cord;
      pkt_r.x_cord     <= dest_i.x_cord;
    end
  end

  assign pkt_v_o = pkt_v_r;
  assign pkt_o   = pkt_r;

endmodule

`default_nettype wire

//--- hdl/mc_return_reorder.sv
`timescale 1ns/1ns
`default_nettype none

module mc_return_reorder
  import mc_bridge_pkg::*;
  (input  logic               clk_i
   , input  logic             rst_n_i

   // slot allocation from the issue stage
   , input  logic             alloc_v_i
   , input  logic [TID_W-1:0] alloc_id_i
   , input  mc_hdr_s          alloc_hdr_i

   // returns from the network, any order
   , input  logic             ret_v_i
   , input  mc_ret_s          ret_i

   , output logic             resp_v_o
   , output mc_resp_s         resp_o
   , output logic             rel_v_o
   );

  mc_hdr_s               hdr_mem  [MAX_OUT];
  logic [MC_DATA_W-1:0]  data_mem [MAX_OUT];
  logic [MAX_OUT-1:0]    done_r;
  logic [TID_W-1:0]      head_r;

  logic [TID_W-1:0]      ret_id;
  logic                  ret_hits_head;
  logic                  head_ready;
  logic [MC_DATA_W-1:0]  head_data;

  logic                  resp_v_r;
  mc_resp_s              resp_r;

  // low bits of the reg id carry the transaction id
  assign ret_id = ret_i.reg_id[TID_W-1:0];

  ////////////////////////////////////////////////////////////
  // slot storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (alloc_v_i)
      hdr_mem[alloc_id_i] <= alloc_hdr_i;
    if (ret_v_i)
      data_mem[ret_id] <= ret_i.data;
  end

  ////////////////////////////////////////////////////////////
  // head release
  ////////////////////////////////////////////////////////////
  // a return to the head slot is forwarded straight into the response
  assign ret_hits_head = ret_v_i & (ret_id == head_r);
  assign head_ready    = done_r[head_r] | ret_hits_head;
  assign head_data     = done_r[head_r] ? data_mem[head_r] : ret_i.data;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      done_r   <= '0;
      head_r   <= '0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      resp_v_r <= head_ready;

      if (ret_v_i)
        done_r[ret_id] <= 1'b1;

      // release wins over a same-cycle fill of the head slot
      if (head_ready)
      begin
        done_r[head_r] <= 1'b0;
        head_r         <= head_r + 1'b1;
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i)
  begin
    if (head_ready)
    begin
      resp_r.hdr  <= hdr_mem[head_r];
      resp_r.data <= head_data;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;
  // slot count drops in the same cycle the response goes out
  assign rel_v_o  = resp_v_r;

endmodule

`default_nettype wire

//--- sim.f
hdl/mc_bridge_pkg.sv
hdl/mc_dest_map.sv
hdl/mc_op_encode.sv
hdl/mc_req_issue.sv
hdl/mc_return_reorder.sv
hdl/mc_bridge.sv
sim/tb_clock_gen.sv
sim/tb_mc_bridge.sv

//--- sim/mc_bridge_golden.txt
# C type size addr data | R reg_id data | S type size addr data   (all hex)
# P addr op reg_id payload src_y src_x y x   (all hex)
# tile read word
C 0 2 C01440048C 00000000
P 0000123 0 00 00000000 02 03 05 04
R 00 CAFE0001
S 0 2 C01440048C CAFE0001
# tile byte store at byte 1
C 1 0 C0FC180005 0000AB00
P 0020001 1 09 0000AB00 02 03 3F 01
R 09 00000000
S 1 0 C0FC180005 00000000
# dram half read at byte 2
C 0 1 0080001246 00000000
P 0800012 0 02 00000006 02 03 3F 11
R 02 00001234
S 0 1 0080001246 00001234
# host word store below the dram base
C 1 2 0000001000 DEADBEEF
P 0000400 2 3F DEADBEEF 02 03 01 00
R 3F 00000000
S 1 2 0000001000 00000000
# host byte read with top bits 10
C 0 0 8000000013 00000000
P 0000004 0 00 0000000B 02 03 01 00
R 00 000000EF
S 0 0 8000000013 000000EF
# dram half store at byte 2
C 1 1 0090000042 56780000
P 0900000 1 31 56780000 02 03 3F 10
R 31 00000000
S 1 1 0090000042 00000000
# dram byte store at byte 3
C 1 0 00A0000007 9A000000
P 0A00000 1 22 9A000000 02 03 3F 01
R 22 00000000
S 1 0 00A0000007 00000000
# tile half store
C 1 1 C0295FFFFC 0000BEEF
P 003FFFF 1 0F 0000BEEF 02 03 0A 15
R 0F 00000000
S 1 1 C0295FFFFC 00000000
# four outstanding, returned as ids 2 0 3 1
C 0 2 C004200040 00000000
P 0000010 0 00 00000000 02 03 01 02
C 0 2 0080000100 00000000
P 0800001 0 01 00000000 02 03 3F 00
C 0 2 0000002000 00000000
P 0000800 0 02 00000000 02 03 01 00
C 1 2 C00830000C 12345678
P 0000003 2 3F 12345678 02 03 02 03
R 02 B2B2B2B2
R 00 B0B0B0B0
R 3F 00000000
R 01 B1B1B1B1
S 0 2 C004200040 B0B0B0B0
S 0 2 0080000100 B1B1B1B1
S 0 2 0000002000 B2B2B2B2
S 1 2 C00830000C 00000000

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
  (output logic   clk_o
   , output logic rst_n_o
   );

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 10;

  // 4 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held for ten rising edges, released on a falling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_mc_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mc_bridge
  import mc_bridge_pkg::*;
  ();

  localparam int             MAX_REC    = 128;
  localparam int             WAIT_LIMIT = 200;
  localparam logic [X_W-1:0] MY_X       = 6'h03;
  localparam logic [Y_W-1:0] MY_Y       = 6'h02;

  logic            clk;
  logic            rst_n;
  logic            cmd_v;
  mc_cmd_s         cmd;
  logic            cmd_ready;
  logic [X_W-1:0]  my_x;
  logic [Y_W-1:0]  my_y;
  logic            pkt_v;
  mc_packet_s      pkt;
  logic            ret_v;
  mc_ret_s         ret;
  logic            resp_v;
  mc_resp_s        resp;

  // C, R and P records in file order, S records go to the response queue
  logic [7:0]      rec_tag [MAX_REC];
  logic [63:0]     rec_fld [MAX_REC][8];
  int              n_rec;
  int              next_p;
  mc_resp_s        exp_resp_q [$];
  mc_resp_s        exp_resp;

  int              error_cnt;
  int              timeout_cnt;
  int              check_cnt;
  int              n_cmd;
  int              n_acc;
  int              n_rel;
  int              n_pkt;
  logic            run_checks;
  logic            exp_ready;

  tb_clock_gen u_clock_gen
    (.clk_o    (clk)
     ,.rst_n_o (rst_n)
     );

  mc_bridge u_dut
    (.clk_i        (clk)
     ,.rst_n_i     (rst_n)
     ,.cmd_v_i     (cmd_v)
     ,.cmd_i       (cmd)
     ,.cmd_ready_o (cmd_ready)
     ,.my_x_i      (my_x)
     ,.my_y_i      (my_y)
     ,.pkt_v_o     (pkt_v)
     ,.pkt_o       (pkt)
     ,.ret_v_i     (ret_v)
     ,.ret_i       (ret)
     ,.resp_v_o    (resp_v)
     ,.resp_o      (resp)
     );

  ////////////////////////////////////////////////////////////
  // golden file
  ////////////////////////////////////////////////////////////
  task automatic load_golden();
    int                fd;
    int                code;
    logic [7:0]        tag;
    logic [63:0]       a0, a1, a2, a3, a4, a5, a6, a7;
    logic [8*160-1:0]  rest;
    mc_resp_s          r;
    n_rec = 0;
    fd = $fopen("sim/mc_bridge_golden.txt", "r");
    if (fd == 0)
    begin
      $display("could not open sim/mc_bridge_golden.txt");
      error_cnt++;
      return;
    end
    while (n_rec < MAX_REC)
    begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1)
        break;
      if (tag == "#")
        code = $fgets(rest, fd);
      else if (tag == "C" || tag == "S")
        code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
      else if (tag == "R")
        code = $fscanf(fd, "%h %h", a0, a1);
      else if (tag == "P")
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6, a7);
      else
      begin
        $display("golden file holds a record of unknown kind");
        error_cnt++;
        break;
      end
      if (tag == "S")
      begin
        r.hdr.msg_type = msg_type_e'(a0[0]);
        r.hdr.size     = msg_size_e'(a1[1:0]);
        r.hdr.addr     = a2[PADDR_W-1:0];
        r.data         = a3[MC_DATA_W-1:0];
        exp_resp_q.push_back(r);
      end
      else if (tag != "#")
      begin
        rec_tag[n_rec]    = tag;
        rec_fld[n_rec][0] = a0;
        rec_fld[n_rec][1] = a1;
        rec_fld[n_rec][2] = a2;
        rec_fld[n_rec][3] = a3;
        rec_fld[n_rec][4] = a4;
        rec_fld[n_rec][5] = a5;
        rec_fld[n_rec][6] = a6;
        rec_fld[n_rec][7] = a7;
        n_rec++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // drivers, entered and left on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic issue_command(input int idx);
    int          cycles;
    mc_packet_s  exp_pkt;
    cycles = 0;
    while (cmd_ready !== 1'b1 && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_ready !== 1'b1)
    begin
      $display("timeout while waiting for cmd_ready_o before command %0d", n_cmd);
      timeout_cnt++;
      return;
    end
    cmd_v            = 1'b1;
    cmd.hdr.msg_type = msg_type_e'(rec_fld[idx][0][0]);
    cmd.hdr.size     = msg_size_e'(rec_fld[idx][1][1:0]);
    cmd.hdr.addr     = rec_fld[idx][2][PADDR_W-1:0];
    cmd.data         = rec_fld[idx][3][MC_DATA_W-1:0];
    n_cmd++;
    @(negedge clk);
    cmd_v = 1'b0;

    // the packet comes exactly one cycle after the command
    if (next_p <= idx)
      next_p = idx + 1;
    while (next_p < n_rec && rec_tag[next_p] != "P")
      next_p++;
    if (next_p >= n_rec)
    begin
      $display("golden file has no packet record for command %0d", n_cmd - 1);
      error_cnt++;
      return;
    end
    exp_pkt.addr       = rec_fld[next_p][0][MC_ADDR_W-1:0];
    exp_pkt.op         = mc_op_e'(rec_fld[next_p][1][1:0]);
    exp_pkt.reg_id     = rec_fld[next_p][2][REG_ID_W-1:0];
    exp_pkt.payload    = rec_fld[next_p][3][MC_DATA_W-1:0];
    exp_pkt.src_y_cord = rec_fld[next_p][4][Y_W-1:0];
    exp_pkt.src_x_cord = rec_fld[next_p][5][X_W-1:0];
    exp_pkt.y_cord     = rec_fld[next_p][6][Y_W-1:0];
    exp_pkt.x_cord     = rec_fld[next_p][7][X_W-1:0];
    next_p++;
    check_cnt++;
    if (pkt_v !== 1'b1 || pkt !== exp_pkt)
    begin
      $display("[ERROR] %0t: packet of command %0d, valid %b, got %h, expected %h",
               $time, n_cmd - 1, pkt_v, pkt, exp_pkt);
      error_cnt++;
    end
  endtask

  task automatic drive_return(input int idx);
    ret_v      = 1'b1;
    ret.reg_id = rec_fld[idx][0][REG_ID_W-1:0];
    ret.data   = rec_fld[idx][1][MC_DATA_W-1:0];
    @(negedge clk);
    ret_v = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // monitor
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (run_checks && cmd_v)
      n_acc <= n_acc + 1;
  end

  always @(negedge clk)
  begin
    if (run_checks)
    begin
      // slot count drops in the release cycle, ready follows a cycle later
      exp_ready = ((n_acc - n_rel) < MAX_OUT);
      check_cnt++;
      if (cmd_ready !== exp_ready)
      begin
        $display("[ERROR] %0t: cmd_ready_o is %b, expected %b with %0d outstanding",
                 $time, cmd_ready, exp_ready, n_acc - n_rel);
        error_cnt++;
      end
      if (pkt_v === 1'b1)
        n_pkt++;
      if (resp_v === 1'b1)
      begin
        n_rel++;
        if (exp_resp_q.size() == 0)
        begin
          $display("[ERROR] %0t: response %h with none expected", $time, resp);
          error_cnt++;
        end
        else
        begin
          exp_resp = exp_resp_q.pop_front();
          check_cnt++;
          if (resp !== exp_resp)
          begin
            $display("[ERROR] %0t: response %0d, got %h, expected %h",
                     $time, n_rel - 1, resp, exp_resp);
            error_cnt++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int i;
    int cycles;
    cmd_v       = 1'b0;
    cmd         = '0;
    ret_v       = 1'b0;
    ret         = '0;
    my_x        = MY_X;
    my_y        = MY_Y;
    error_cnt   = 0;
    timeout_cnt = 0;
    check_cnt   = 0;
    n_cmd       = 0;
    n_acc       = 0;
    n_rel       = 0;
    n_pkt       = 0;
    next_p      = 0;
    run_checks  = 1'b0;
    load_golden();

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("timeout while waiting for reset release");
      timeout_cnt++;
    end
    else
    begin
      run_checks = 1'b1;
      @(negedge clk);
      check_cnt++;
      if (pkt_v !== 1'b0 || resp_v !== 1'b0)
      begin
        $display("[ERROR] %0t: after reset pkt_v_o %b resp_v_o %b", $time, pkt_v, resp_v);
        error_cnt++;
      end
      for (i = 0; i < n_rec && timeout_cnt == 0; i++)
      begin
        if (rec_tag[i] == "C")
          issue_command(i);
        else if (rec_tag[i] == "R")
          drive_return(i);
      end

      // remaining responses drain in order
      cycles = 0;
      while (exp_resp_q.size() != 0 && cycles < WAIT_LIMIT)
      begin
        @(negedge clk);
        cycles++;
      end
      if (exp_resp_q.size() != 0)
      begin
        $display("timeout with %0d responses never delivered", exp_resp_q.size());
        timeout_cnt++;
      end
      // quiet tail to catch stray packets or responses
      repeat (8) @(negedge clk);
      check_cnt++;
      if (n_pkt != n_cmd)
      begin
        $display("[ERROR] %0t: %0d packets for %0d commands", $time, n_pkt, n_cmd);
        error_cnt++;
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", check_cnt, error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
